/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = tb_i3c_ccc
FILELIST  = i3c_ccc.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* ccc/ccc_frame_fsm.sv */
// Frame state machine that walks a CCC frame and issues the bus requests
`timescale 1ns/100ps
`default_nettype none

module ccc_frame_fsm
  import ccc_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic [7:0]    ccc_i,
  input  logic          ccc_valid_i,
  input  ccc_addr_cfg_t addr_cfg_i,
  input  logic [7:0]    bus_rx_data_i,
  input  logic          bus_rx_done_i,
  input  logic          bus_tx_done_i,
  input  logic          bus_rstart_det_i,
  input  logic          bus_stop_det_i,
  input  logic [7:0]    get_byte_i,
  input  logic          get_last_i,
  output ccc_bus_req_t  bus_req_o,
  output logic          done_o,
  output logic [7:0]    cmd_code_o,
  output logic          tbit_done_o,
  output logic          data_tbit_done_o,
  output ccc_rx_byte_u  rx_byte_o,
  output logic [7:0]    data_idx_o,
  output logic          addr_match_o,
  output logic          get_load_o,
  output logic          get_sent_o
);

  ccc_state_e   state_q;
  ccc_state_e   state_d;
  logic [7:0]   cmd_q;
  ccc_rx_byte_u addr_q;
  ccc_rx_byte_u rx_byte_q;
  logic [7:0]   data_idx_q;
  logic         is_direct;
  logic         has_def_byte;
  logic         addr_rsvd;
  logic         addr_match;
  logic         new_cmd;
  logic         new_addr;

  assign is_direct    = cmd_q[CCC_DIRECT_BIT];
  assign has_def_byte = cmd_q inside {CCC_BCAST_ENDXFER, CCC_BCAST_RSTACT,
                                      CCC_DIRECT_ENDXFER, CCC_DIRECT_RSTACT};
  assign addr_rsvd    = addr_q.da.addr == I3C_RSVD_ADDR;
  assign new_cmd      = state_q == ST_WAIT && ccc_valid_i;
  assign new_addr     = state_q == ST_DIRECT_ADDR && bus_rx_done_i;

  // Dynamic address wins once assigned
  always_comb begin
    if (addr_cfg_i.dyn_valid) begin
      addr_match = addr_q.da.addr == addr_cfg_i.dyn_addr;
    end else if (addr_cfg_i.sta_valid) begin
      addr_match = addr_q.da.addr == addr_cfg_i.sta_addr;
    end else begin
      addr_match = 1'b0;
    end
  end

  // Address is cleared per command so broadcast data never sees a stale 7E
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmd_q  <= '0;
      addr_q <= '0;
    end else if (new_cmd) begin
      cmd_q  <= ccc_i;
      addr_q <= '0;
    end else if (new_addr) begin
      addr_q <= bus_rx_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      data_idx_q <= '0;
    end else if (new_cmd || new_addr) begin
      data_idx_q <= '0;
    end else if (state_q == ST_RX_TBIT && bus_rx_done_i) begin
      data_idx_q <= data_idx_q + 8'd1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rx_byte_q <= '0;
    end else if (state_q == ST_RX_DATA && bus_rx_done_i) begin
      rx_byte_q <= bus_rx_data_i;
    end
  end

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ST_IDLE: state_d = ST_WAIT;
      ST_WAIT: if (ccc_valid_i) state_d = ST_TBIT;
      ST_TBIT: begin
        if (bus_rx_done_i) begin
          if (cmd_q == CCC_BCAST_ENTDAA || has_def_byte) state_d = ST_WAIT_STOP;
          else if (is_direct) state_d = ST_DIRECT_BYTE;
          else state_d = ST_RX_DATA;
        end
      end
      // Only a repeated start is legal before the first direct address
      ST_DIRECT_BYTE: begin
        if (bus_rstart_det_i) state_d = ST_DIRECT_ADDR;
        else if (bus_rx_done_i) state_d = ST_WAIT_STOP;
      end
      ST_DIRECT_ADDR: if (bus_rx_done_i) state_d = ST_ADDR_ACK;
      ST_ADDR_ACK: begin
        if (bus_tx_done_i) begin
          if (addr_rsvd) state_d = ST_WAIT_STOP;
          else if (addr_match && addr_q.da.rnw) state_d = ST_TX_DATA;
          else if (addr_match) state_d = ST_RX_DATA;
          else state_d = ST_WAIT_BUS_COND;
        end
      end
      ST_RX_DATA: begin
        if (bus_rstart_det_i) state_d = ST_DIRECT_ADDR;
        else if (bus_rx_done_i) state_d = ST_RX_TBIT;
      end
      ST_RX_TBIT: if (bus_rx_done_i) state_d = ST_RX_DATA;
      ST_TX_DATA: begin
        if (bus_rstart_det_i) state_d = ST_DIRECT_ADDR;
        else if (bus_tx_done_i) state_d = ST_TX_TBIT;
      end
      ST_TX_TBIT: begin
        if (bus_tx_done_i) state_d = get_last_i ? ST_WAIT_BUS_COND : ST_TX_DATA;
      end
      ST_WAIT_BUS_COND: if (bus_rstart_det_i) state_d = ST_DIRECT_ADDR;
      ST_DONE: state_d = ST_IDLE;
      default: state_d = state_q;
    endcase
  end

  // STOP ends the frame from any state
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
    end else if (bus_stop_det_i) begin
      state_q <= ST_DONE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    bus_req_o = '0;
    unique case (state_q)
      ST_TBIT, ST_RX_TBIT: bus_req_o.req_bit = 1'b1;
      ST_DIRECT_BYTE, ST_RX_DATA: bus_req_o.req_byte = !bus_rstart_det_i;
      ST_DIRECT_ADDR: bus_req_o.req_byte = 1'b1;
      // Open-drain ACK bit that NACKs a foreign address
      ST_ADDR_ACK: begin
        bus_req_o.req_bit = 1'b1;
        bus_req_o.value   = {7'b0, !(addr_match || addr_rsvd)};
      end
      ST_TX_DATA: begin
        bus_req_o.req_byte  = !bus_rstart_det_i;
        bus_req_o.sel_od_pp = 1'b1;
        bus_req_o.value     = get_byte_i;
      end
      ST_TX_TBIT: begin
        bus_req_o.req_bit   = 1'b1;
        bus_req_o.sel_od_pp = 1'b1;
        bus_req_o.value     = {7'b0, !get_last_i};
      end
      default: bus_req_o = '0;
    endcase
  end

  assign done_o           = state_q == ST_DONE;
  assign tbit_done_o      = state_q == ST_TBIT && bus_rx_done_i;
  assign data_tbit_done_o = state_q == ST_RX_TBIT && bus_rx_done_i && !addr_rsvd;
  assign get_load_o       = tbit_done_o || (state_q == ST_ADDR_ACK && bus_tx_done_i);
  assign get_sent_o       = state_q == ST_TX_DATA && bus_tx_done_i;
  assign cmd_code_o       = cmd_q;
  assign rx_byte_o        = rx_byte_q;
  assign data_idx_o       = data_idx_q;
  assign addr_match_o     = addr_match;

endmodule

`default_nettype wire

/* ccc/ccc_get_tx.sv */
// GET byte counter that selects the outgoing CSR bytes most significant first
`timescale 1ns/100ps
`default_nettype none

module ccc_get_tx
  import ccc_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic [7:0]    cmd_code_i,
  input  ccc_get_data_t get_data_i,
  input  logic          get_load_i,
  input  logic          get_sent_i,
  output logic [7:0]    get_byte_o,
  output logic          get_last_o
);

  logic [2:0] count_q;
  logic [2:0] count_init;

  function automatic logic [7:0] pick_16(logic [15:0] word, logic [2:0] cnt);
    logic [7:0] sel;
    sel = 8'h00;
    if (cnt == 3'd2) sel = word[15:8];
    else if (cnt == 3'd1) sel = word[7:0];
    return sel;
  endfunction

  always_comb begin
    case (cmd_code_i)
      CCC_DIRECT_GETBCR, CCC_DIRECT_GETDCR:    count_init = 3'd1;
      CCC_DIRECT_GETSTATUS, CCC_DIRECT_GETMWL: count_init = 3'd2;
      CCC_DIRECT_GETMRL:                       count_init = 3'd3;
      CCC_DIRECT_GETPID:                       count_init = 3'd6;
      default:                                 count_init = 3'd0;
    endcase
  end

  // Saturates at zero when a read runs past the end
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else if (get_load_i) begin
      count_q <= count_init;
    end else if (get_sent_i && count_q != 3'd0) begin
      count_q <= count_q - 3'd1;
    end
  end

  always_comb begin
    get_byte_o = 8'h00;
    case (cmd_code_i)
      CCC_DIRECT_GETBCR: if (count_q == 3'd1) get_byte_o = get_data_i.bcr;
      CCC_DIRECT_GETDCR: if (count_q == 3'd1) get_byte_o = get_data_i.dcr;
      CCC_DIRECT_GETSTATUS: get_byte_o = pick_16(get_data_i.status, count_q);
      CCC_DIRECT_GETMWL: get_byte_o = pick_16(get_data_i.mwl, count_q);
      // Third byte is the max IBI payload size
      CCC_DIRECT_GETMRL: begin
        if (count_q == 3'd1) get_byte_o = GETMRL_IBI_SIZE;
        else get_byte_o = pick_16(get_data_i.mrl, count_q - 3'd1);
      end
      CCC_DIRECT_GETPID: begin
        case (count_q)
          3'd6: get_byte_o = get_data_i.pid[47:40];
          3'd5: get_byte_o = get_data_i.pid[39:32];
          3'd4: get_byte_o = get_data_i.pid[31:24];
          3'd3: get_byte_o = get_data_i.pid[23:16];
          3'd2: get_byte_o = get_data_i.pid[15:8];
          3'd1: get_byte_o = get_data_i.pid[7:0];
          default: get_byte_o = 8'h00;
        endcase
      end
      default: get_byte_o = 8'h00;
    endcase
  end

  assign get_last_o = count_q == 3'd0;

endmodule

`default_nettype wire

/* ccc/ccc_set_regs.sv */
// Registers and strobes written by the SET, ENEC, DISEC and address CCCs
`timescale 1ns/100ps
`default_nettype none

module ccc_set_regs
  import ccc_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic [7:0]    cmd_code_i,
  input  ccc_addr_cfg_t addr_cfg_i,
  input  logic          tbit_done_i,
  input  logic          data_tbit_done_i,
  input  ccc_rx_byte_u  rx_byte_i,
  input  logic [7:0]    data_idx_i,
  input  logic          addr_match_i,
  input  logic          done_i,
  output logic [15:0]   mwl_o,
  output logic          set_mwl_o,
  output logic [15:0]   mrl_o,
  output logic          set_mrl_o,
  output ccc_events_t   enec_o,
  output ccc_events_t   disec_o,
  output logic          rstdaa_o,
  output logic [6:0]    dasa_o,
  output logic          set_dasa_o,
  output logic          status_read_o
);

  logic accept;
  logic first_byte;
  logic is_setmwl;
  logic is_setmrl;
  logic is_enec;
  logic is_disec;
  logic status_open_q;

  // Direct data only counts for the addressed target
  assign accept     = data_tbit_done_i && (!cmd_code_i[CCC_DIRECT_BIT] || addr_match_i);
  assign first_byte = accept && data_idx_i == 8'd0;
  assign is_setmwl  = cmd_code_i inside {CCC_BCAST_SETMWL, CCC_DIRECT_SETMWL};
  assign is_setmrl  = cmd_code_i inside {CCC_BCAST_SETMRL, CCC_DIRECT_SETMRL};
  assign is_enec    = cmd_code_i inside {CCC_BCAST_ENEC, CCC_DIRECT_ENEC};
  assign is_disec   = cmd_code_i inside {CCC_BCAST_DISEC, CCC_DIRECT_DISEC};

  // Length words arrive high byte first and strobe after the low byte
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mwl_o     <= '0;
      set_mwl_o <= 1'b0;
      mrl_o     <= '0;
      set_mrl_o <= 1'b0;
    end else begin
      set_mwl_o <= 1'b0;
      set_mrl_o <= 1'b0;
      if (accept && is_setmwl) begin
        if (data_idx_i == 8'd0) mwl_o[15:8] <= rx_byte_i;
        else if (data_idx_i == 8'd1) begin
          mwl_o[7:0] <= rx_byte_i;
          set_mwl_o  <= 1'b1;
        end
      end
      if (accept && is_setmrl) begin
        if (data_idx_i == 8'd0) mrl_o[15:8] <= rx_byte_i;
        else if (data_idx_i == 8'd1) begin
          mrl_o[7:0] <= rx_byte_i;
          set_mrl_o  <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      enec_o  <= '0;
      disec_o <= '0;
    end else if (first_byte && is_enec) begin
      enec_o <= '{hj: rx_byte_i.ev.hj, crr: rx_byte_i.ev.crr, ibi: rx_byte_i.ev.ibi};
    end else if (first_byte && is_disec) begin
      disec_o <= '{hj: rx_byte_i.ev.hj, crr: rx_byte_i.ev.crr, ibi: rx_byte_i.ev.ibi};
    end
  end

  // SETAASA and SETDASA share one dynamic address strobe
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dasa_o     <= '0;
      set_dasa_o <= 1'b0;
      rstdaa_o   <= 1'b0;
    end else begin
      set_dasa_o <= 1'b0;
      rstdaa_o   <= tbit_done_i && cmd_code_i == CCC_BCAST_RSTDAA;
      if (tbit_done_i && cmd_code_i == CCC_BCAST_SETAASA && addr_cfg_i.sta_valid) begin
        dasa_o     <= addr_cfg_i.sta_addr;
        set_dasa_o <= 1'b1;
      end else if (first_byte && cmd_code_i == CCC_DIRECT_SETDASA) begin
        dasa_o     <= rx_byte_i.da.addr;
        set_dasa_o <= 1'b1;
      end
    end
  end

  // GETSTATUS read is reported once the frame closes
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      status_open_q <= 1'b0;
      status_read_o <= 1'b0;
    end else begin
      status_read_o <= status_open_q && done_i && addr_match_i;
      if (done_i) status_open_q <= 1'b0;
      else if (tbit_done_i && cmd_code_i == CCC_DIRECT_GETSTATUS) status_open_q <= 1'b1;
    end
  end

endmodule

`default_nettype wire

/* common/ccc_pkg.sv */
// Shared command codes, bus types and frame states of the I3C target CCC handler
`default_nettype none

package ccc_pkg;

  // Broadcast command codes
  localparam logic [7:0] CCC_BCAST_ENEC     = 8'h00;
  localparam logic [7:0] CCC_BCAST_DISEC    = 8'h01;
  localparam logic [7:0] CCC_BCAST_RSTDAA   = 8'h06;
  localparam logic [7:0] CCC_BCAST_ENTDAA   = 8'h07;
  localparam logic [7:0] CCC_BCAST_SETMWL   = 8'h09;
  localparam logic [7:0] CCC_BCAST_SETMRL   = 8'h0A;
  localparam logic [7:0] CCC_BCAST_SETAASA  = 8'h29;

  // Direct command codes
  localparam logic [7:0] CCC_DIRECT_ENEC      = 8'h80;
  localparam logic [7:0] CCC_DIRECT_DISEC     = 8'h81;
  localparam logic [7:0] CCC_DIRECT_SETDASA   = 8'h87;
  localparam logic [7:0] CCC_DIRECT_SETMWL    = 8'h89;
  localparam logic [7:0] CCC_DIRECT_SETMRL    = 8'h8A;
  localparam logic [7:0] CCC_DIRECT_GETMWL    = 8'h8B;
  localparam logic [7:0] CCC_DIRECT_GETMRL    = 8'h8C;
  localparam logic [7:0] CCC_DIRECT_GETPID    = 8'h8D;
  localparam logic [7:0] CCC_DIRECT_GETBCR    = 8'h8E;
  localparam logic [7:0] CCC_DIRECT_GETDCR    = 8'h8F;
  localparam logic [7:0] CCC_DIRECT_GETSTATUS = 8'h90;

  // Codes with a defining byte that are not supported here
  localparam logic [7:0] CCC_BCAST_ENDXFER  = 8'h12;
  localparam logic [7:0] CCC_BCAST_RSTACT   = 8'h2A;
  localparam logic [7:0] CCC_DIRECT_ENDXFER = 8'h92;
  localparam logic [7:0] CCC_DIRECT_RSTACT  = 8'h9A;

  localparam logic [6:0]  I3C_RSVD_ADDR   = 7'h7E;
  localparam logic [7:0]  GETMRL_IBI_SIZE = 8'hFF;
  localparam int unsigned CCC_DIRECT_BIT  = 7;

  typedef struct packed {
    logic [6:0] sta_addr;
    logic       sta_valid;
    logic [6:0] dyn_addr;
    logic       dyn_valid;
  } ccc_addr_cfg_t;

  typedef struct packed {
    logic       req_bit;
    logic       req_byte;
    logic       sel_od_pp;
    logic [7:0] value;
  } ccc_bus_req_t;

  typedef struct packed {
    logic [7:0]  bcr;
    logic [7:0]  dcr;
    logic [15:0] status;
    logic [15:0] mwl;
    logic [15:0] mrl;
    logic [47:0] pid;
  } ccc_get_data_t;

  typedef struct packed {
    logic hj;
    logic crr;
    logic ibi;
  } ccc_events_t;

  // One received byte read as a direct address or as ENEC/DISEC flags
  typedef union packed {
    struct packed {
      logic [6:0] addr;
      logic       rnw;
    } da;
    struct packed {
      logic [3:0] rsvd_hi;
      logic       hj;
      logic       rsvd;
      logic       crr;
      logic       ibi;
    } ev;
  } ccc_rx_byte_u;

  typedef enum logic [3:0] {
    ST_IDLE,
    ST_WAIT,
    ST_TBIT,
    ST_DIRECT_BYTE,
    ST_DIRECT_ADDR,
    ST_ADDR_ACK,
    ST_RX_DATA,
    ST_RX_TBIT,
    ST_TX_DATA,
    ST_TX_TBIT,
    ST_WAIT_BUS_COND,
    ST_WAIT_STOP,
    ST_DONE
  } ccc_state_e;

endpackage

`default_nettype wire

/* i3c_ccc.f */
common/ccc_pkg.sv
ccc/ccc_frame_fsm.sv
ccc/ccc_get_tx.sv
ccc/ccc_set_regs.sv
rtl/i3c_ccc.sv
test/tb_clk_gen.sv
test/i3c_ccc_assert.sv
test/tb_i3c_ccc.sv

/* rtl/i3c_ccc.sv */
// I3C target CCC handler top with frame FSM, GET source and SET registers
`timescale 1ns/100ps
`default_nettype none

module i3c_ccc
  import ccc_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic [7:0]    ccc_i,
  input  logic          ccc_valid_i,
  input  ccc_addr_cfg_t addr_cfg_i,
  input  ccc_get_data_t get_data_i,
  input  logic [7:0]    bus_rx_data_i,
  input  logic          bus_rx_done_i,
  input  logic          bus_tx_done_i,
  input  logic          bus_rstart_det_i,
  input  logic          bus_stop_det_i,
  output ccc_bus_req_t  bus_req_o,
  output logic          done_o,
  output logic [15:0]   mwl_o,
  output logic          set_mwl_o,
  output logic [15:0]   mrl_o,
  output logic          set_mrl_o,
  output ccc_events_t   enec_o,
  output ccc_events_t   disec_o,
  output logic          rstdaa_o,
  output logic [6:0]    dasa_o,
  output logic          set_dasa_o,
  output logic          status_read_o
);

  logic [7:0]   cmd_code;
  logic         tbit_done;
  logic         data_tbit_done;
  ccc_rx_byte_u rx_byte;
  logic [7:0]   data_idx;
  logic         addr_match;
  logic         get_load;
  logic         get_sent;
  logic [7:0]   get_byte;
  logic         get_last;

  ccc_frame_fsm ccc_frame_fsm_i (
    .clk_i,
    .rst_ni,
    .ccc_i,
    .ccc_valid_i,
    .addr_cfg_i,
    .bus_rx_data_i,
    .bus_rx_done_i,
    .bus_tx_done_i,
    .bus_rstart_det_i,
    .bus_stop_det_i,
    .get_byte_i       (get_byte),
    .get_last_i       (get_last),
    .bus_req_o,
    .done_o,
    .cmd_code_o       (cmd_code),
    .tbit_done_o      (tbit_done),
    .data_tbit_done_o (data_tbit_done),
    .rx_byte_o        (rx_byte),
    .data_idx_o       (data_idx),
    .addr_match_o     (addr_match),
    .get_load_o       (get_load),
    .get_sent_o       (get_sent)
  );

  ccc_get_tx ccc_get_tx_i (
    .clk_i,
    .rst_ni,
    .cmd_code_i (cmd_code),
    .get_data_i,
    .get_load_i (get_load),
    .get_sent_i (get_sent),
    .get_byte_o (get_byte),
    .get_last_o (get_last)
  );

  ccc_set_regs ccc_set_regs_i (
    .clk_i,
    .rst_ni,
    .cmd_code_i       (cmd_code),
    .addr_cfg_i,
    .tbit_done_i      (tbit_done),
    .data_tbit_done_i (data_tbit_done),
    .rx_byte_i        (rx_byte),
    .data_idx_i       (data_idx),
    .addr_match_i     (addr_match),
    .done_i           (done_o),
    .mwl_o,
    .set_mwl_o,
    .mrl_o,
    .set_mrl_o,
    .enec_o,
    .disec_o,
    .rstdaa_o,
    .dasa_o,
    .set_dasa_o,
    .status_read_o
  );

endmodule

`default_nettype wire

/* test/i3c_ccc_assert.sv */
// Concurrent checks on the frame FSM bus requests and done pulse
`timescale 1ns/100ps
`default_nettype none

module i3c_ccc_assert
  import ccc_pkg::*;
(
  input logic         clk_i,
  input logic         rst_ni,
  input ccc_bus_req_t bus_req_i,
  input logic         done_i,
  input ccc_state_e   state_i
);

  // Done is a single cycle pulse
  done_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_i |=> !done_i)
    else $error("done held longer than one cycle");

  req_exclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(bus_req_i.req_bit && bus_req_i.req_byte))
    else $error("bit and byte request high together");

  // Leaving reset the FSM is idle with no byte request
  reset_quiet: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> (!bus_req_i.req_byte && state_i == ST_IDLE))
    else $error("byte request or state not clean after reset");

endmodule

`default_nettype wire

/* test/i3c_ccc_patterns.txt */
# code addr nd d0 d1 d2 d3 d4 d5 ack ng g0 g1 g2 g3 g4 g5 mwl mrl enec disec dasa
#   then pulse counts: set_mwl set_mrl rstdaa set_dasa status_read (all hex, addr FF = none)
09 FF 2 12 34 00 00 00 00 0 0 00 00 00 00 00 00 1234 0000 0 0 00 1 0 0 0 0
0A FF 2 00 80 00 00 00 00 0 0 00 00 00 00 00 00 1234 0080 0 0 00 0 1 0 0 0
00 FF 1 09 00 00 00 00 00 0 0 00 00 00 00 00 00 1234 0080 5 0 00 0 0 0 0 0
81 62 1 02 00 00 00 00 00 0 0 00 00 00 00 00 00 1234 0080 5 2 00 0 0 0 0 0
80 80 0 00 00 00 00 00 00 1 0 00 00 00 00 00 00 1234 0080 5 2 00 0 0 0 0 0
8E 63 0 00 00 00 00 00 00 0 1 A6 00 00 00 00 00 1234 0080 5 2 00 0 0 0 0 0
8F 63 0 00 00 00 00 00 00 0 1 C3 00 00 00 00 00 1234 0080 5 2 00 0 0 0 0 0
90 63 0 00 00 00 00 00 00 0 2 80 01 00 00 00 00 1234 0080 5 2 00 0 0 0 0 1
8B 63 0 00 00 00 00 00 00 0 2 02 20 00 00 00 00 1234 0080 5 2 00 0 0 0 0 0
8C 63 0 00 00 00 00 00 00 0 3 04 40 FF 00 00 00 1234 0080 5 2 00 0 0 0 0 0
8D 63 0 00 00 00 00 00 00 0 6 01 23 45 67 89 AB 1234 0080 5 2 00 0 0 0 0 0
06 FF 0 00 00 00 00 00 00 0 0 00 00 00 00 00 00 1234 0080 5 2 00 0 0 1 0 0
29 FF 0 00 00 00 00 00 00 0 0 00 00 00 00 00 00 1234 0080 5 2 52 0 0 0 1 0
87 62 1 5A 00 00 00 00 00 0 0 00 00 00 00 00 00 1234 0080 5 2 2D 0 0 0 1 0
89 80 0 00 00 00 00 00 00 1 0 00 00 00 00 00 00 1234 0080 5 2 2D 0 0 0 0 0
01 FF 1 01 00 00 00 00 00 0 0 00 00 00 00 00 00 1234 0080 5 1 2D 0 0 0 0 0
89 62 2 AB CD 00 00 00 00 0 0 00 00 00 00 00 00 ABCD 0080 5 1 2D 1 0 0 0 0

/* test/tb_clk_gen.sv */
// Clock and reset source for the CCC testbench with a 10 ns period
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // Reset held for five cycles
  initial begin
    rst_no = 1'b0;
    repeat (5) @(posedge clk_o);
    #1 rst_no = 1'b1;
  end

endmodule

`default_nettype wire

/* test/tb_i3c_ccc.sv */
// Testbench for the CCC handler with a pattern driven bus model
`timescale 1ns/100ps
`default_nettype none

module tb_i3c_ccc
  import ccc_pkg::*;
();

  localparam int NFLD = 27;
  localparam int MAXREC = 32;

  logic          clk_i;
  logic          rst_ni;
  logic [7:0]    ccc_i;
  logic          ccc_valid_i;
  ccc_addr_cfg_t addr_cfg_i;
  ccc_get_data_t get_data_i;
  logic [7:0]    bus_rx_data_i;
  logic          bus_rx_done_i;
  logic          bus_tx_done_i;
  logic          bus_rstart_det_i;
  logic          bus_stop_det_i;
  ccc_bus_req_t  bus_req_o;
  logic          done_o;
  logic [15:0]   mwl_o;
  logic          set_mwl_o;
  logic [15:0]   mrl_o;
  logic          set_mrl_o;
  ccc_events_t   enec_o;
  ccc_events_t   disec_o;
  logic          rstdaa_o;
  logic [6:0]    dasa_o;
  logic          set_dasa_o;
  logic          status_read_o;

  int          seed;
  int          num_recs = 0;
  logic [31:0] recs [MAXREC][NFLD];
  // Pulse counts of set_mwl, set_mrl, rstdaa, set_dasa, status_read and done
  int          pulse_cnt [6] = '{0, 0, 0, 0, 0, 0};

  tb_clk_gen tb_clk_gen_i (
    .clk_o  (clk_i),
    .rst_no (rst_ni)
  );

  i3c_ccc i3c_ccc_i (.*);

  bind ccc_frame_fsm i3c_ccc_assert i3c_ccc_assert_i (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .bus_req_i (bus_req_o),
    .done_i    (done_o),
    .state_i   (state_q)
  );

  always @(posedge clk_i) begin
    if (set_mwl_o) pulse_cnt[0] <= pulse_cnt[0] + 1;
    if (set_mrl_o) pulse_cnt[1] <= pulse_cnt[1] + 1;
    if (rstdaa_o) pulse_cnt[2] <= pulse_cnt[2] + 1;
    if (set_dasa_o) pulse_cnt[3] <= pulse_cnt[3] + 1;
    if (status_read_o) pulse_cnt[4] <= pulse_cnt[4] + 1;
    if (done_o) pulse_cnt[5] <= pulse_cnt[5] + 1;
  end

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
      $display("sim failed");
      $fatal(1, "value check failed");
    end
  endtask

  // Bus engine answers after 0 to 3 idle cycles
  task automatic bus_delay();
    int r;
    r = $random(seed);
    repeat (r[1:0]) @(posedge clk_i);
    @(posedge clk_i);
  endtask

  task automatic wait_bit_req(output logic [7:0] val);
    @(negedge clk_i);
    while (!bus_req_o.req_bit) @(negedge clk_i);
    val = bus_req_o.value;
  endtask

  task automatic wait_byte_req(output logic [7:0] val);
    @(negedge clk_i);
    while (!bus_req_o.req_byte) @(negedge clk_i);
    val = bus_req_o.value;
  endtask

  task automatic rx_pulse(input logic [7:0] data);
    bus_delay();
    #1;
    bus_rx_data_i = data;
    bus_rx_done_i = 1'b1;
    @(posedge clk_i);
    #1 bus_rx_done_i = 1'b0;
  endtask

  task automatic tx_pulse();
    bus_delay();
    #1 bus_tx_done_i = 1'b1;
    @(posedge clk_i);
    #1 bus_tx_done_i = 1'b0;
  endtask

  task automatic rstart_pulse();
    bus_delay();
    #1 bus_rstart_det_i = 1'b1;
    @(posedge clk_i);
    #1 bus_rstart_det_i = 1'b0;
  endtask

  task automatic stop_pulse();
    bus_delay();
    #1 bus_stop_det_i = 1'b1;
    @(posedge clk_i);
    #1 bus_stop_det_i = 1'b0;
  endtask

  task automatic load_patterns();
    int fd;
    int n;
    string line;
    logic [31:0] f [NFLD];
    fd = $fopen("test/i3c_ccc_patterns.txt", "r");
    if (fd == 0) begin
      $display("sim failed");
      $fatal(1, "cannot open the pattern file");
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() > 1 && line.getc(0) != "#") begin
        n = $sscanf(line,
          "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
          f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
          f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19],
          f[20], f[21], f[22], f[23], f[24], f[25], f[26]);
        if (n != NFLD || num_recs == MAXREC) begin
          $display("sim failed");
          $fatal(1, "pattern file has a malformed line or too many lines");
        end
        recs[num_recs] = f;
        num_recs = num_recs + 1;
      end
    end
    $fclose(fd);
  endtask

  task automatic run_record(input int idx);
    logic [31:0] r [NFLD];
    int base [6];
    logic [7:0] v;
    logic direct;
    r = recs[idx];
    base = pulse_cnt;
    // Bit 7 of the code marks a direct CCC
    direct = r[0][7];
    @(posedge clk_i);
    #1;
    ccc_i = r[0][7:0];
    ccc_valid_i = 1'b1;
    wait_bit_req(v);
    @(posedge clk_i);
    #1 ccc_valid_i = 1'b0;
    rx_pulse(8'h00);
    if (direct) begin
      wait_byte_req(v);
      rstart_pulse();
      wait_byte_req(v);
      rx_pulse(r[1][7:0]);
      wait_bit_req(v);
      check("address ACK bit", 32'(v[0]), r[9]);
      check("address ACK push-pull select", 32'(bus_req_o.sel_od_pp), 32'd0);
      tx_pulse();
    end
    if (direct && r[1][0]) begin
      for (int k = 0; k < int'(r[10]); k++) begin
        wait_byte_req(v);
        check("GET data byte", 32'(v), r[11 + k]);
        check("GET data push-pull select", 32'(bus_req_o.sel_od_pp), 32'd1);
        tx_pulse();
        wait_bit_req(v);
        check("GET T-bit", 32'(v[0]), 32'(k != int'(r[10]) - 1));
        check("GET T-bit push-pull select", 32'(bus_req_o.sel_od_pp), 32'd1);
        tx_pulse();
      end
    end else begin
      for (int k = 0; k < int'(r[2]); k++) begin
        wait_byte_req(v);
        rx_pulse(r[3 + k][7:0]);
        wait_bit_req(v);
        rx_pulse(8'h00);
      end
    end
    stop_pulse();
    repeat (4) @(posedge clk_i);
    #1;
    check("mwl_o", 32'(mwl_o), r[17]);
    check("mrl_o", 32'(mrl_o), r[18]);
    check("enec_o", 32'(enec_o), r[19]);
    check("disec_o", 32'(disec_o), r[20]);
    check("dasa_o", 32'(dasa_o), r[21]);
    check("set_mwl_o pulses", 32'(pulse_cnt[0] - base[0]), r[22]);
    check("set_mrl_o pulses", 32'(pulse_cnt[1] - base[1]), r[23]);
    check("rstdaa_o pulses", 32'(pulse_cnt[2] - base[2]), r[24]);
    check("set_dasa_o pulses", 32'(pulse_cnt[3] - base[3]), r[25]);
    check("status_read_o pulses", 32'(pulse_cnt[4] - base[4]), r[26]);
    check("done_o pulses", 32'(pulse_cnt[5] - base[5]), 32'd1);
  endtask

  initial begin
    seed = 32'hfafff0da;
    ccc_i = 8'h00;
    ccc_valid_i = 1'b0;
    addr_cfg_i = '{sta_addr: 7'h52, sta_valid: 1'b1, dyn_addr: 7'h31, dyn_valid: 1'b1};
    get_data_i = '{bcr: 8'hA6, dcr: 8'hC3, status: 16'h8001, mwl: 16'h0220,
                   mrl: 16'h0440, pid: 48'h0123_4567_89AB};
    bus_rx_data_i = 8'h00;
    bus_rx_done_i = 1'b0;
    bus_tx_done_i = 1'b0;
    bus_rstart_det_i = 1'b0;
    bus_stop_det_i = 1'b0;
    load_patterns();
    if (num_recs == 0) begin
      $display("sim failed");
      $fatal(1, "pattern file holds no records");
    end
    wait (rst_ni === 1'b1);
    repeat (3) @(posedge clk_i);
    for (int i = 0; i < num_recs; i++) begin
      run_record(i);
    end
    $display("sim passed");
    $finish;
  end

  // Watchdog scaled by the number of records
  initial begin
    wait (num_recs > 0);
    #(num_recs * 2000);
    $display("sim failed");
    $fatal(1, "timeout, the run did not finish in time");
  end

endmodule

`default_nettype wire
